//--- project.f
verilog/mul_params_pkg.sv
verilog/mul_types_pkg.sv
verilog/operand_prep.sv
verilog/partial_products.sv
verilog/csa_layer.sv
verilog/wallace_reduce.sv
verilog/final_adder.sv
verilog/multiplier_top.sv
testbench/tb_multiplier.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_multiplier -f project.f \
	-Mdir obj_dir -o tb_multiplier > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_multiplier > sim.log 2>&1 ; cat sim.log

grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- testbench/tb_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_multiplier import mul_params_pkg::*, mul_types_pkg::*;;

	localparam int clk_period     = 20;
	localparam int reset_cycles   = 2;
	localparam int n_rows         = 64;
	localparam int timeout_cycles = reset_cycles + n_rows + mul_latency + 20;

	typedef struct packed {
		logic                  gap;                 // hold valid low for this row.
		mul_op_e               op;
		logic [op_width-1:0]   a;
		logic [op_width-1:0]   b;
		logic [prod_width-1:0] expected;
	} stim_t;

	logic                  clk;
	logic                  rst;
	logic                  valid;
	mul_op_e               op;
	logic [op_width-1:0]   a;
	logic [op_width-1:0]   b;
	logic [prod_width-1:0] ans;
	logic                  rdy;

	stim_t                 stim [n_rows];
	int                    n_fill;
	logic [31:0]           lcg_state;
	int                    edge_count = 0;
	int                    value_errors = 0;
	int                    protocol_errors = 0;

	logic [prod_width-1:0] exp_q [$];
	int                    edge_q [$];            // cycle in which each valid is high.
	logic [prod_width-1:0] want;
	int                    sent_edge;

	multiplier_top DUT (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.op    (op),
		.a     (a),
		.b     (b),
		.ans   (ans),
		.rdy   (rdy)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// full product with operands widened by their own reading, kept mod 2^64.
	function automatic logic [prod_width-1:0] expected_product(input mul_op_e op_in,
			input logic [op_width-1:0] x, input logic [op_width-1:0] y);
		logic [prod_width-1:0] wx;
		logic [prod_width-1:0] wy;
		wx = {32'd0, x};
		wy = {32'd0, y};
		if (op_in == op_smul || op_in == op_sumul)
			wx = {{32{x[31]}}, x};
		if (op_in == op_smul)
			wy = {{32{y[31]}}, y};
		return wx * wy;
	endfunction

	task automatic check_value(input string name, input logic [prod_width-1:0] got,
			input logic [prod_width-1:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("FAIL %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic add_row(input logic gap, input mul_op_e op_in,
			input logic [op_width-1:0] x, input logic [op_width-1:0] y);
		stim[n_fill].gap      = gap;
		stim[n_fill].op       = op_in;
		stim[n_fill].a        = x;
		stim[n_fill].b        = y;
		stim[n_fill].expected = expected_product(op_in, x, y);
		n_fill++;
	endtask

	task automatic fill_table();
		logic [31:0] r;
		logic [31:0] opa;
		mul_op_e     rop;
		n_fill = 0;
		add_row(1'b0, op_umul, 32'h0000_0000, 32'h0000_0000);
		add_row(1'b0, op_umul, 32'h0000_0000, 32'hffff_ffff);
		add_row(1'b0, op_umul, 32'h0000_0001, 32'h0000_0001);
		add_row(1'b0, op_umul, 32'h0000_0001, 32'h1234_5678);
		add_row(1'b0, op_umul, 32'h0000_0002, 32'h8000_0000);
		add_row(1'b0, op_umul, 32'h0001_0000, 32'h0001_0000);
		add_row(1'b0, op_umul, 32'h8000_0000, 32'h8000_0000);
		add_row(1'b0, op_umul, 32'hffff_ffff, 32'hffff_ffff);
		add_row(1'b1, op_umul, 32'hdead_beef, 32'h0000_0003);
		add_row(1'b0, op_smul, 32'hffff_ffff, 32'h0000_0005);   // -1 times 5.
		add_row(1'b0, op_smul, 32'h8000_0000, 32'hffff_ffff);   // most negative times -1.
		add_row(1'b0, op_smul, 32'h8000_0000, 32'h8000_0000);
		add_row(1'b0, op_smul, 32'hffff_fff6, 32'h0000_0007);
		add_row(1'b0, op_smul, 32'hffff_fff6, 32'hffff_fff9);
		add_row(1'b0, op_smul, 32'h7fff_ffff, 32'h7fff_ffff);
		add_row(1'b0, op_smul, 32'h7fff_ffff, 32'h8000_0000);
		add_row(1'b1, op_smul, 32'h0000_0000, 32'h0000_0000);
		add_row(1'b1, op_smul, 32'h0000_0000, 32'h0000_0000);
		add_row(1'b0, op_sumul, 32'hffff_ffff, 32'hffff_ffff);
		add_row(1'b0, op_sumul, 32'h8000_0000, 32'hffff_ffff);
		add_row(1'b0, op_sumul, 32'hffff_fffe, 32'h8000_0000);
		add_row(1'b0, op_sumul, 32'h1234_5678, 32'hffff_ffff);
		add_row(1'b0, op_sumul, 32'h7fff_ffff, 32'hffff_ffff);
		while (n_fill < n_rows) begin
			lcg_state = lcg_next(lcg_state);
			r = lcg_state;
			case (r[9:8])
				2'd0:    rop = op_umul;
				2'd1:    rop = op_smul;
				default: rop = op_sumul;
			endcase
			lcg_state = lcg_next(lcg_state);
			opa = lcg_state;
			lcg_state = lcg_next(lcg_state);
			add_row(r[31:29] == 3'd0, rop, opa, lcg_state);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// clock, counters, watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) edge_count <= edge_count + 1;

	initial begin
		#(timeout_cycles * clk_period);
		$display("watchdog expired after %0d clock periods, results still pending",
			timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor, sampled away from the active edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		if (rst) begin
			check_value("rdy", {63'd0, rdy}, 64'd0);
		end else if (rdy === 1'b1) begin
			if (exp_q.size() == 0) begin
				protocol_errors++;
				$display("rdy pulsed at edge %0d with no result pending", edge_count);
			end else begin
				want      = exp_q.pop_front();
				sent_edge = edge_q.pop_front();
				check_value("ans", ans, want);
				check_value("rdy_latency", 64'(edge_count - sent_edge), 64'(mul_latency));
			end
		end else if (rdy !== 1'b0) begin
			protocol_errors++;
			$display("rdy is unknown at edge %0d", edge_count);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst       = 1'b1;
		valid     = 1'b0;
		op        = op_umul;
		a         = '0;
		b         = '0;
		lcg_state = 32'hc2d8;
		fill_table();
		repeat (reset_cycles) @(posedge clk);
		#1 rst = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			valid = ~stim[i].gap;
			op    = stim[i].op;
			a     = stim[i].a;
			b     = stim[i].b;
			if (!stim[i].gap) begin
				exp_q.push_back(stim[i].expected);
				edge_q.push_back(edge_count);        // valid is high from this edge on.
			end
			@(posedge clk);
			#1;
		end
		valid = 1'b0;
		repeat (mul_latency + 2) @(posedge clk);    // drain the pipe.
		if (exp_q.size() != 0) begin
			protocol_errors++;
			$display("%0d results never came out of the pipeline", exp_q.size());
		end
		$display("errors: %0d value mismatches, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/csa_layer.sv
`timescale 1ns/1ps
`default_nettype none

module csa_layer import mul_params_pkg::*; #(
	parameter  int in_rows  = 3,
	localparam int out_rows = (in_rows / 3) * 2 + in_rows % 3
) (
	input  logic [prod_width-1:0] rows_in  [in_rows],
	output logic [prod_width-1:0] rows_out [out_rows]
);

	localparam int groups = in_rows / 3;
	localparam int rest   = in_rows % 3;

	genvar g;
	genvar r;

	// 3:2 compressors, each group of three rows becomes a sum and a carry row.
	for (g = 0; g < groups; g++) begin : gen_group
		logic [prod_width-1:0] x;
		logic [prod_width-1:0] y;
		logic [prod_width-1:0] z;

		assign x = rows_in[3*g];
		assign y = rows_in[3*g+1];
		assign z = rows_in[3*g+2];

		assign rows_out[2*g]   = x ^ y ^ z;
		assign rows_out[2*g+1] = ((x & y) | (y & z) | (x & z)) << 1;   // carry weight is one up.
	end

	// leftover rows skip this layer.
	for (r = 0; r < rest; r++) begin : gen_pass
		assign rows_out[2*groups+r] = rows_in[3*groups+r];
	end

endmodule

`default_nettype wire

//--- verilog/final_adder.sv
`timescale 1ns/1ps
`default_nettype none

module final_adder import mul_params_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  logic [prod_width-1:0] sum_row,
	input  logic [prod_width-1:0] carry_row,
	input  logic                  neg,
	output logic [prod_width-1:0] ans,
	output logic                  rdy
);

	logic [prod_width-1:0] total;

	assign total = sum_row + carry_row;             // carry out of bit 63 is dropped.

	always_ff @(posedge clk) begin
		ans <= neg ? -total : total;
	end

	always_ff @(posedge clk) begin
		if (rst)
			rdy <= 1'b0;
		else
			rdy <= valid;
	end

endmodule

`default_nettype wire

//--- verilog/mul_params_pkg.sv
`default_nettype none

package mul_params_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand and product sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int op_width   = 32;
	localparam int prod_width = 64;
	localparam int pp_rows    = 32;                 // one row per bit of b.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// wallace reduction schedule
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rows entering each carry-save layer, last entry is what leaves layer 7.
	localparam int layer_rows [0:8] = '{32, 22, 15, 10, 7, 5, 4, 3, 2};

	localparam int reduce_stages = 4;               // two layers per register bank.

	// prep + partial products + reduction banks + final add.
	localparam int mul_latency = 2 + reduce_stages + 1;

endpackage

`default_nettype wire

//--- verilog/mul_types_pkg.sv
`default_nettype none

package mul_types_pkg;

	// operand interpretation for a multiply.
	typedef enum logic [1:0] {
		op_umul  = 2'd0,    // unsigned a times unsigned b.
		op_smul  = 2'd1,    // signed a times signed b.
		op_sumul = 2'd2     // signed a times unsigned b.
	} mul_op_e;

endpackage

`default_nettype wire

//--- verilog/multiplier_top.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier_top import mul_params_pkg::*, mul_types_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  mul_op_e               op,
	input  logic [op_width-1:0]   a,
	input  logic [op_width-1:0]   b,
	output logic [prod_width-1:0] ans,
	output logic                  rdy
);

	logic [op_width-1:0]   mag_a;
	logic [op_width-1:0]   mag_b;
	logic                  prep_neg;
	logic                  prep_valid;

	logic [prod_width-1:0] pp_rows_q [pp_rows];
	logic                  pp_neg;
	logic                  pp_valid;

	logic [prod_width-1:0] sum_row;
	logic [prod_width-1:0] carry_row;
	logic                  red_neg;
	logic                  red_valid;

	operand_prep u_prep (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.mag_a     (mag_a),
		.mag_b     (mag_b),
		.neg       (prep_neg),
		.valid_out (prep_valid)
	);

	partial_products u_pp (
		.clk       (clk),
		.rst       (rst),
		.valid     (prep_valid),
		.mag_a     (mag_a),
		.mag_b     (mag_b),
		.neg       (prep_neg),
		.rows      (pp_rows_q),
		.neg_out   (pp_neg),
		.valid_out (pp_valid)
	);

	wallace_reduce u_reduce (
		.clk       (clk),
		.rst       (rst),
		.valid     (pp_valid),
		.rows      (pp_rows_q),
		.neg       (pp_neg),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.neg_out   (red_neg),
		.valid_out (red_valid)
	);

	final_adder u_add (
		.clk       (clk),
		.rst       (rst),
		.valid     (red_valid),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.neg       (red_neg),
		.ans       (ans),
		.rdy       (rdy)
	);

endmodule

`default_nettype wire

//--- verilog/operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

module operand_prep import mul_params_pkg::*, mul_types_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  mul_op_e             op,
	input  logic [op_width-1:0] a,
	input  logic [op_width-1:0] b,
	output logic [op_width-1:0] mag_a,
	output logic [op_width-1:0] mag_b,
	output logic                neg,
	output logic                valid_out
);

	logic a_signed;
	logic b_signed;
	logic a_neg;
	logic b_neg;

	always_comb begin
		a_signed = 1'b0;
		b_signed = 1'b0;
		case (op)
			op_smul: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			op_sumul: a_signed = 1'b1;
			default: ;                              // unused code multiplies unsigned.
		endcase
	end

	assign a_neg = a_signed & a[op_width-1];
	assign b_neg = b_signed & b[op_width-1];

	// 2^31 fits as an unsigned magnitude.
	always_ff @(posedge clk) begin
		mag_a <= a_neg ? -a : a;
		mag_b <= b_neg ? -b : b;
		neg   <= a_neg ^ b_neg;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_out <= 1'b0;
		else
			valid_out <= valid;
	end

endmodule

`default_nettype wire

//--- verilog/partial_products.sv
`timescale 1ns/1ps
`default_nettype none

module partial_products import mul_params_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  logic [op_width-1:0]   mag_a,
	input  logic [op_width-1:0]   mag_b,
	input  logic                  neg,
	output logic [prod_width-1:0] rows [pp_rows],
	output logic                  neg_out,
	output logic                  valid_out
);

	logic [prod_width-1:0] a_wide;

	assign a_wide = prod_width'(mag_a);

	// row i is a shifted by i where bit i of b is set.
	always_ff @(posedge clk) begin
		for (int i = 0; i < pp_rows; i++) begin
			rows[i] <= mag_b[i] ? (a_wide << i) : '0;
		end
		neg_out <= neg;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_out <= 1'b0;
		else
			valid_out <= valid;
	end

endmodule

`default_nettype wire

//--- verilog/wallace_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module wallace_reduce import mul_params_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid,
	input  logic [prod_width-1:0] rows [pp_rows],
	input  logic                  neg,
	output logic [prod_width-1:0] sum_row,
	output logic [prod_width-1:0] carry_row,
	output logic                  neg_out,
	output logic                  valid_out
);

	logic [prod_width-1:0] l1_rows [layer_rows[1]];
	logic [prod_width-1:0] l2_rows [layer_rows[2]];
	logic [prod_width-1:0] st1     [layer_rows[2]];
	logic [prod_width-1:0] l3_rows [layer_rows[3]];
	logic [prod_width-1:0] l4_rows [layer_rows[4]];
	logic [prod_width-1:0] st2     [layer_rows[4]];
	logic [prod_width-1:0] l5_rows [layer_rows[5]];
	logic [prod_width-1:0] l6_rows [layer_rows[6]];
	logic [prod_width-1:0] st3     [layer_rows[6]];
	logic [prod_width-1:0] l7_rows [layer_rows[7]];
	logic [prod_width-1:0] l8_rows [layer_rows[8]];

	logic [reduce_stages-1:0] neg_sr;
	logic [reduce_stages-1:0] valid_sr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, 32 rows to 15
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	csa_layer #(.in_rows(layer_rows[0])) u_layer0 (.rows_in(rows),    .rows_out(l1_rows));
	csa_layer #(.in_rows(layer_rows[1])) u_layer1 (.rows_in(l1_rows), .rows_out(l2_rows));

	always_ff @(posedge clk) st1 <= l2_rows;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, 15 rows to 7
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	csa_layer #(.in_rows(layer_rows[2])) u_layer2 (.rows_in(st1),     .rows_out(l3_rows));
	csa_layer #(.in_rows(layer_rows[3])) u_layer3 (.rows_in(l3_rows), .rows_out(l4_rows));

	always_ff @(posedge clk) st2 <= l4_rows;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 3, 7 rows to 4
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	csa_layer #(.in_rows(layer_rows[4])) u_layer4 (.rows_in(st2),     .rows_out(l5_rows));
	csa_layer #(.in_rows(layer_rows[5])) u_layer5 (.rows_in(l5_rows), .rows_out(l6_rows));

	always_ff @(posedge clk) st3 <= l6_rows;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 4, 4 rows to sum and carry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	csa_layer #(.in_rows(layer_rows[6])) u_layer6 (.rows_in(st3),     .rows_out(l7_rows));
	csa_layer #(.in_rows(layer_rows[7])) u_layer7 (.rows_in(l7_rows), .rows_out(l8_rows));

	always_ff @(posedge clk) begin
		sum_row   <= l8_rows[0];
		carry_row <= l8_rows[1];
	end

	// sign and valid ride along with the banks.
	always_ff @(posedge clk) begin
		neg_sr <= {neg_sr[reduce_stages-2:0], neg};
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[reduce_stages-2:0], valid};
	end

	assign neg_out   = neg_sr[reduce_stages-1];
	assign valid_out = valid_sr[reduce_stages-1];

endmodule

`default_nettype wire
